// ==== rtl/cpu16_pkg.sv ====
package cpu16_pkg;

  ////////////////////////////////////////////////////////////////////
  // Machine dimensions
  ////////////////////////////////////////////////////////////////////

  localparam int DATA_W = 16;
  localparam int NUM_REGS = 16;
  localparam int APB_ADDR_W = 8;

  typedef logic [3:0] reg_idx_t;

  // Unlisted codes fall through as no-operations
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SHL  = 4'd5,
    OP_SHR  = 4'd6,
    OP_LDI  = 4'd8,
    OP_LUI  = 4'd9,
    OP_ADDI = 4'd10
  } opcode_t;

  ////////////////////////////////////////////////////////////////////
  // Instruction word, two views of the same 16 bits
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
  } instr_reg_t;

  typedef struct packed {
    opcode_t    opcode;
    reg_idx_t   rd;
    logic [7:0] imm;
  } instr_imm_t;

  typedef union packed {
    instr_reg_t r;
    instr_imm_t i;
  } instr_t;

  // APB map
  localparam logic [APB_ADDR_W-1:0] INSTR_ADDR = 8'h00;
  localparam logic [APB_ADDR_W-1:0] REG_BASE = 8'h40;

endpackage

// ==== rtl/exec_if.sv ====
// One decoded operation on its way from operand read to execute
interface exec_if;

  logic                        valid;
  cpu16_pkg::opcode_t          op;
  cpu16_pkg::reg_idx_t         rd;
  logic [cpu16_pkg::DATA_W-1:0] opa;
  logic [cpu16_pkg::DATA_W-1:0] opb;

  // Operand read stage drives everything
  modport source (
    output valid, op, rd, opa, opb
  );

  // Execute stage consumes everything
  modport sink (
    input valid, op, rd, opa, opb
  );

  // Issue logic only needs the destination for hazard checks
  modport monitor (
    input valid, rd
  );

endinterface

// ==== rtl/register_file.sv ====
module register_file (
  input  logic                         clk,
  input  logic                         rst_n,
  input  cpu16_pkg::reg_idx_t          rd_sel_1,
  input  cpu16_pkg::reg_idx_t          rd_sel_2,
  input  cpu16_pkg::reg_idx_t          dbg_sel,
  input  logic                         wr_en,
  input  cpu16_pkg::reg_idx_t          wr_sel,
  input  logic [cpu16_pkg::DATA_W-1:0] wr_data,
  output logic [cpu16_pkg::DATA_W-1:0] rd_data_1,
  output logic [cpu16_pkg::DATA_W-1:0] rd_data_2,
  output logic [cpu16_pkg::DATA_W-1:0] dbg_data
);

  logic [cpu16_pkg::DATA_W-1:0] regs [cpu16_pkg::NUM_REGS];

  ////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////

  // All registers come up as zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < cpu16_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_sel] <= wr_data;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////////////

  // No bypass, a write shows up the cycle after its edge
  always_comb begin
    rd_data_1 = regs[rd_sel_1];
    rd_data_2 = regs[rd_sel_2];
  end

  // Host side view for APB register reads
  always_comb begin
    dbg_data = regs[dbg_sel];
  end

endmodule

// ==== rtl/apb_issue.sv ====
module apb_issue (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [cpu16_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [cpu16_pkg::DATA_W-1:0]     pwdata,
  output logic                             pready,
  output logic [cpu16_pkg::DATA_W-1:0]     prdata,
  output logic                             pslverr,
  output logic                             issue_valid,
  output cpu16_pkg::instr_t                issue_word,
  exec_if.monitor                          ex,
  output cpu16_pkg::reg_idx_t              dbg_sel,
  input  logic [cpu16_pkg::DATA_W-1:0]     dbg_data
);

  cpu16_pkg::instr_t   offered;
  cpu16_pkg::reg_idx_t src_a;
  cpu16_pkg::reg_idx_t src_b;
  logic                src_a_used;
  logic                src_b_used;
  logic                hit_a;
  logic                hit_b;
  logic                hazard;
  logic                pipe_empty;
  logic                is_instr;
  logic                is_reg_rd;
  logic                bad_addr;
  logic                access;

  ////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////

  assign access    = psel && penable;
  assign is_instr  = pwrite && (paddr == cpu16_pkg::INSTR_ADDR);
  // Window is REG_BASE .. REG_BASE + 15
  assign is_reg_rd = !pwrite && (paddr[7:4] == cpu16_pkg::REG_BASE[7:4]);
  assign bad_addr  = !is_instr && !is_reg_rd;
  assign dbg_sel   = paddr[3:0];

  // Source registers of the word on the bus
  assign offered = cpu16_pkg::instr_t'(pwdata);

  always_comb begin
    src_a      = offered.r.rs1;
    src_b      = offered.r.rs2;
    src_a_used = 1'b0;
    src_b_used = 1'b0;
    case (offered.r.opcode)
      cpu16_pkg::OP_ADD, cpu16_pkg::OP_SUB, cpu16_pkg::OP_AND, cpu16_pkg::OP_OR,
      cpu16_pkg::OP_XOR, cpu16_pkg::OP_SHL, cpu16_pkg::OP_SHR: begin
        src_a_used = 1'b1;
        src_b_used = 1'b1;
      end
      // Immediate ops that modify rd read it first
      cpu16_pkg::OP_ADDI, cpu16_pkg::OP_LUI: begin
        src_a      = offered.i.rd;
        src_a_used = 1'b1;
      end
      default: ;
    endcase
  end

  // Compare against both in-flight destinations
  assign hit_a = (issue_valid && issue_word.i.rd == src_a) || (ex.valid && ex.rd == src_a);
  assign hit_b = (issue_valid && issue_word.i.rd == src_b) || (ex.valid && ex.rd == src_b);
  assign hazard = (src_a_used && hit_a) || (src_b_used && hit_b);

  assign pipe_empty = !issue_valid && !ex.valid;

  ////////////////////////////////////////////////////////////////////
  // APB response
  ////////////////////////////////////////////////////////////////////

  assign pready  = access && (bad_addr || (is_instr && !hazard) || (is_reg_rd && pipe_empty));
  assign pslverr = access && bad_addr;
  assign prdata  = (access && is_reg_rd) ? dbg_data : '0;

  // Issue stage register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= pready && is_instr;
    end
  end

  always_ff @(posedge clk) begin
    if (pready && is_instr) begin
      issue_word <= offered;
    end
  end

endmodule

// ==== rtl/operand_read.sv ====
module operand_read (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         issue_valid,
  input  cpu16_pkg::instr_t            issue_word,
  input  logic [cpu16_pkg::DATA_W-1:0] rd_data_1,
  input  logic [cpu16_pkg::DATA_W-1:0] rd_data_2,
  output cpu16_pkg::reg_idx_t          rd_sel_1,
  output cpu16_pkg::reg_idx_t          rd_sel_2,
  exec_if.source                       ex
);

  logic [cpu16_pkg::DATA_W-1:0] opb_next;
  logic [7:0]                   imm;

  assign imm = issue_word.i.imm;

  // Register form reads rs1/rs2, the rest read rd on port 1
  always_comb begin
    rd_sel_1 = issue_word.i.rd;
    rd_sel_2 = issue_word.r.rs2;
    case (issue_word.r.opcode)
      cpu16_pkg::OP_ADD, cpu16_pkg::OP_SUB, cpu16_pkg::OP_AND, cpu16_pkg::OP_OR,
      cpu16_pkg::OP_XOR, cpu16_pkg::OP_SHL, cpu16_pkg::OP_SHR: begin
        rd_sel_1 = issue_word.r.rs1;
      end
      default: ;
    endcase
  end

  // addi takes a signed byte, ldi and lui an unsigned one
  always_comb begin
    case (issue_word.i.opcode)
      cpu16_pkg::OP_ADDI: opb_next = {{(cpu16_pkg::DATA_W-8){imm[7]}}, imm};
      cpu16_pkg::OP_LDI,
      cpu16_pkg::OP_LUI:  opb_next = {{(cpu16_pkg::DATA_W-8){1'b0}}, imm};
      default:            opb_next = rd_data_2;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex.valid <= 1'b0;
    end else begin
      ex.valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    ex.op  <= issue_word.r.opcode;
    ex.rd  <= issue_word.r.rd;
    ex.opa <= rd_data_1;
    ex.opb <= opb_next;
  end

endmodule

// ==== rtl/alu_execute.sv ====
module alu_execute (
  exec_if.sink                         ex,
  output logic                         wr_en,
  output cpu16_pkg::reg_idx_t          wr_sel,
  output logic [cpu16_pkg::DATA_W-1:0] wr_data
);

  logic [cpu16_pkg::DATA_W-1:0] result;
  logic                         writes;

  ////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    result = '0;
    writes = 1'b1;
    case (ex.op)
      cpu16_pkg::OP_ADD: result = ex.opa + ex.opb;
      cpu16_pkg::OP_SUB: result = ex.opa - ex.opb;
      cpu16_pkg::OP_AND: result = ex.opa & ex.opb;
      cpu16_pkg::OP_OR:  result = ex.opa | ex.opb;
      cpu16_pkg::OP_XOR: result = ex.opa ^ ex.opb;
      // Shift amount is the low nibble only
      cpu16_pkg::OP_SHL: result = ex.opa << ex.opb[3:0];
      cpu16_pkg::OP_SHR: result = ex.opa >> ex.opb[3:0];
      cpu16_pkg::OP_LDI: result = ex.opb;
      // Upper byte from the immediate, low byte of rd kept
      cpu16_pkg::OP_LUI: result = {ex.opb[7:0], ex.opa[7:0]};
      cpu16_pkg::OP_ADDI: result = ex.opa + ex.opb;
      default: begin
        writes = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // Write-back
  ////////////////////////////////////////////////////////////////////

  assign wr_en   = ex.valid && writes;
  assign wr_sel  = ex.rd;
  assign wr_data = result;

endmodule

// ==== rtl/cpu16_top.sv ====
module cpu16_top (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [cpu16_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [cpu16_pkg::DATA_W-1:0]     pwdata,
  output logic                             pready,
  output logic [cpu16_pkg::DATA_W-1:0]     prdata,
  output logic                             pslverr
);

  logic                         issue_valid;
  cpu16_pkg::instr_t            issue_word;
  cpu16_pkg::reg_idx_t          rd_sel_1;
  cpu16_pkg::reg_idx_t          rd_sel_2;
  logic [cpu16_pkg::DATA_W-1:0] rd_data_1;
  logic [cpu16_pkg::DATA_W-1:0] rd_data_2;
  cpu16_pkg::reg_idx_t          dbg_sel;
  logic [cpu16_pkg::DATA_W-1:0] dbg_data;
  logic                         wr_en;
  cpu16_pkg::reg_idx_t          wr_sel;
  logic [cpu16_pkg::DATA_W-1:0] wr_data;

  // Operand read to execute link
  exec_if exec_bus ();

  apb_issue apb_issue_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .pready      (pready),
    .prdata      (prdata),
    .pslverr     (pslverr),
    .issue_valid (issue_valid),
    .issue_word  (issue_word),
    .ex          (exec_bus.monitor),
    .dbg_sel     (dbg_sel),
    .dbg_data    (dbg_data)
  );

  operand_read operand_read_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .issue_word  (issue_word),
    .rd_data_1   (rd_data_1),
    .rd_data_2   (rd_data_2),
    .rd_sel_1    (rd_sel_1),
    .rd_sel_2    (rd_sel_2),
    .ex          (exec_bus.source)
  );

  alu_execute alu_execute_i (
    .ex      (exec_bus.sink),
    .wr_en   (wr_en),
    .wr_sel  (wr_sel),
    .wr_data (wr_data)
  );

  register_file register_file_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_sel_1  (rd_sel_1),
    .rd_sel_2  (rd_sel_2),
    .dbg_sel   (dbg_sel),
    .wr_en     (wr_en),
    .wr_sel    (wr_sel),
    .wr_data   (wr_data),
    .rd_data_1 (rd_data_1),
    .rd_data_2 (rd_data_2),
    .dbg_data  (dbg_data)
  );

endmodule

// ==== verif/cpu16_sva.sv ====
module cpu16_sva (
  input logic clk,
  input logic rst_n,
  input logic psel,
  input logic penable,
  input logic pwrite,
  input logic pready,
  input logic pslverr,
  input logic wr_en,
  input logic issue_valid
);

  logic instr_done;
  logic read_done;

  // Completed transfers as seen on the bus
  assign instr_done = psel && penable && pready && pwrite && !pslverr;
  assign read_done  = psel && penable && pready && !pwrite && !pslverr;

  // Slave stays quiet while reset is held
  a_pready_reset: assert property (@(posedge clk) !rst_n |-> !pready)
    else $error("pready high during reset");

  // An error response ends the transfer and issues nothing
  a_err_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr |-> pready ##1 !issue_valid)
    else $error("pslverr raised without pready or with an issued word");

  // Reset clears the execute stage, so nothing is written back
  a_no_write_reset: assert property (@(posedge clk) !rst_n |=> !wr_en)
    else $error("register write following a reset cycle");

  // An accepted word spends two cycles in flight before its write lands
  a_read_drained: assert property (@(posedge clk) disable iff (!rst_n)
    read_done |-> !$past(instr_done) && !$past(instr_done, 2))
    else $error("register read completed with the pipeline busy");

endmodule

bind cpu16_top cpu16_sva sva_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .psel        (psel),
  .penable     (penable),
  .pwrite      (pwrite),
  .pready      (pready),
  .pslverr     (pslverr),
  .wr_en       (wr_en),
  .issue_valid (issue_valid)
);

// ==== verif/cpu16_tb.sv ====
module cpu16_tb;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [15:0] pwdata;
  logic        pready;
  logic [15:0] prdata;
  logic        pslverr;

  // One transfer per entry, kind 0 marks the end of the list
  logic [47:0] vectors [64];
  int          num_xfers;
  int          cycles;
  int          cycle_limit;

  cpu16_top dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pready  (pready),
    .prdata  (prdata),
    .pslverr (pslverr)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: transfers still running after %0d cycles", cycles);
      $display("TEST RESULT: FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checking and APB driving
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected) begin
      $display("error: %s is 0x%04h, expected 0x%04h", name, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // Called on a rising edge, returns on the completing edge
  task automatic apb_transfer(input int idx);
    logic [3:0] kind;
    logic [3:0] exp_err;
    kind    = vectors[idx][47:44];
    exp_err = vectors[idx][3:0];
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= (kind == 4'h1);
    paddr   <= vectors[idx][43:36];
    pwdata  <= vectors[idx][35:20];
    @(posedge clk);
    penable <= 1'b1;
    // Outputs settle between edges
    @(negedge clk);
    while (!pready) begin
      @(negedge clk);
    end
    check_value($sformatf("pslverr[%0d]", idx), {15'b0, pslverr}, {12'b0, exp_err});
    if (kind == 4'h2) begin
      check_value($sformatf("prdata[%0d]", idx), prdata, vectors[idx][19:4]);
    end
    @(posedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    cycles      = 0;
    cycle_limit = 0;
    num_xfers   = 0;
    for (int i = 0; i < 64; i++) begin
      vectors[i] = '0;
    end
    $readmemh("verif/cpu16_testdata.txt", vectors);
    while (num_xfers < 64 && vectors[num_xfers][47:44] != 4'h0) begin
      num_xfers++;
    end
    cycle_limit = 4 * num_xfers * 4;

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Back to back, so dependent writes meet the hazard stall
    for (int i = 0; i < num_xfers; i++) begin
      apb_transfer(i);
    end
    psel    <= 1'b0;
    penable <= 1'b0;
    @(posedge clk);

    if (num_xfers > 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("no transfers were run from the data file");
      $display("TEST RESULT: FAIL");
      $fatal(1, "empty transfer list");
    end
  end

endmodule

// ==== verif/cpu16_testdata.txt ====
// kind (1 write, 2 read) _ paddr _ pwdata _ expected prdata _ expected pslverr
// Reset state, all sixteen registers read zero
2_40_0000_0000_0
2_41_0000_0000_0
2_42_0000_0000_0
2_43_0000_0000_0
2_44_0000_0000_0
2_45_0000_0000_0
2_46_0000_0000_0
2_47_0000_0000_0
2_48_0000_0000_0
2_49_0000_0000_0
2_4A_0000_0000_0
2_4B_0000_0000_0
2_4C_0000_0000_0
2_4D_0000_0000_0
2_4E_0000_0000_0
2_4F_0000_0000_0
// ldi r1 0x34, lui r1 0x12, then ldi r2 0xF5, addi r2 -3
1_00_8134_0000_0
1_00_9112_0000_0
2_41_0000_1234_0
1_00_82F5_0000_0
1_00_A2FD_0000_0
2_42_0000_00F2_0
// add, sub, and, or, xor, shl, shr of r1 and r2 into r3..r9
1_00_0312_0000_0
1_00_1412_0000_0
1_00_2512_0000_0
1_00_3612_0000_0
1_00_4712_0000_0
1_00_5812_0000_0
1_00_6912_0000_0
2_43_0000_1326_0
2_44_0000_1142_0
2_45_0000_0030_0
2_46_0000_12F6_0
2_47_0000_12C6_0
2_48_0000_48D0_0
2_49_0000_048D_0
// Dependent chain on r10, then unmapped accesses leave it alone
1_00_8A10_0000_0
1_00_AA01_0000_0
1_00_AA01_0000_0
1_00_AA01_0000_0
2_4A_0000_0013_0
1_04_8A55_0000_1
2_3F_0000_0000_1
2_50_0000_0000_1
2_4A_0000_0013_0

// ==== filelist.f ====
rtl/cpu16_pkg.sv
rtl/exec_if.sv
rtl/register_file.sv
rtl/apb_issue.sv
rtl/operand_read.sv
rtl/alu_execute.sv
rtl/cpu16_top.sv
verif/cpu16_sva.sv
verif/cpu16_tb.sv

// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - files:
      - rtl/cpu16_pkg.sv
      - rtl/exec_if.sv
      - rtl/register_file.sv
      - rtl/apb_issue.sv
      - rtl/operand_read.sv
      - rtl/alu_execute.sv
      - rtl/cpu16_top.sv
  - target: test
    files:
      - verif/cpu16_sva.sv
      - verif/cpu16_tb.sv
